//--- rtl/femtoPkg.sv
// Widths and enums shared by the multi-cycle RV32I core
// Every RTL block imports this package
package femtoPkg;

   localparam int XLEN       = 32;  // Data and address width
   localparam int REG_ADDR_W = 5;   // Register index
   localparam int SHAMT_W    = 5;   // Shift amount
   localparam int NUM_REGS   = 32;
   localparam int WMASK_W    = 4;   // One bit per byte lane

   // Major opcodes, instruction bits 6 to 2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcodeT;

   // ALU funct3 codes
   typedef enum logic [2:0] {
      fnAddSub = 3'b000,
      fnSll    = 3'b001,
      fnSlt    = 3'b010,
      fnSltu   = 3'b011,
      fnXor    = 3'b100,
      fnSrlSra = 3'b101,
      fnOr     = 3'b110,
      fnAnd    = 3'b111
   } aluFnT;

   // Branch funct3 codes
   typedef enum logic [2:0] {
      brBeq  = 3'b000,
      brBne  = 3'b001,
      brBlt  = 3'b100,
      brBge  = 3'b101,
      brBltu = 3'b110,
      brBgeu = 3'b111
   } branchCondT;

   // Write-back source
   typedef enum logic [2:0] {
      wbAlu,
      wbUpperImm,
      wbBranchTarget,    // AUIPC result
      wbPcPlus4,         // Link address
      wbLoadData
   } wbSelT;

   // Sequencer states, one-hot
   typedef enum logic [7:0] {
      fetchInstr    = 8'b0000_0001,
      waitInstr     = 8'b0000_0010,
      fetchRegs     = 8'b0000_0100,
      execute       = 8'b0000_1000,
      load          = 8'b0001_0000,
      waitAluOrData = 8'b0010_0000,
      store         = 8'b0100_0000,
      waitIoStore   = 8'b1000_0000
   } coreStateT;

endpackage

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps
// Instruction register and decoding
// Latches the fetched word, then slices fields and builds immediates
module instrDecoder (
   input  logic                            clk,
   input  logic                            instrLoad,
   input  logic [femtoPkg::XLEN-1:0]       memRdata,
   output logic [femtoPkg::REG_ADDR_W-1:0] rd,
   output logic [femtoPkg::REG_ADDR_W-1:0] rs1,
   output logic [femtoPkg::REG_ADDR_W-1:0] rs2,
   output logic [2:0]                      funct3,
   output logic                            altFn,
   output femtoPkg::opcodeT                opcode,
   output femtoPkg::wbSelT                 wbSel,
   output logic [femtoPkg::XLEN-1:0]       immI,
   output logic [femtoPkg::XLEN-1:0]       immS,
   output logic [femtoPkg::XLEN-1:0]       immB,
   output logic [femtoPkg::XLEN-1:0]       immU,
   output logic [femtoPkg::XLEN-1:0]       immJ
);
   import femtoPkg::*;

   logic [XLEN-1:0] instr;  // Latched instruction

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRdata;
      end
   end

   // Register fields
   assign rd     = instr[11:7];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign funct3 = instr[14:12];
   assign altFn  = instr[30];        // SUB and SRA select

   // Five immediate formats, all sign extended from bit 31
   assign immI = {{(XLEN-11){instr[31]}}, instr[30:20]};
   assign immS = {{(XLEN-11){instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   assign opcode = opcodeT'(instr[6:2]);

   // Write-back source per opcode
   always_comb begin
      case (opcode)
         opLui:         wbSel = wbUpperImm;
         opAuipc:       wbSel = wbBranchTarget;
         opJal, opJalr: wbSel = wbPcPlus4;
         opLoad:        wbSel = wbLoadData;
         default:       wbSel = wbAlu;   // ALU ops, unused for branch and store
      endcase
   end

   // Only supported opcodes ever reach the sequencer
   assert property (@(posedge clk) instrLoad |=> instr[6:2] inside
      {opLoad, opAluImm, opAuipc, opStore, opAluReg, opLui, opBranch, opJalr, opJal});

endmodule

//--- rtl/registerBank.sv
`timescale 1ns/1ps
// Register file with registered two-port read
// Write-back value is selected here from the datapath sources
module registerBank (
   input  logic                            clk,
   input  logic [femtoPkg::REG_ADDR_W-1:0] rs1,
   input  logic [femtoPkg::REG_ADDR_W-1:0] rs2,
   input  logic [femtoPkg::REG_ADDR_W-1:0] rd,
   input  logic                            regWrite,
   input  femtoPkg::wbSelT                 wbSel,
   input  logic [femtoPkg::XLEN-1:0]       aluResult,
   input  logic [femtoPkg::XLEN-1:0]       immU,
   input  logic [femtoPkg::XLEN-1:0]       branchTarget,
   input  logic [femtoPkg::XLEN-1:0]       pcPlus4,
   input  logic [femtoPkg::XLEN-1:0]       memRdata,
   output logic [femtoPkg::XLEN-1:0]       rs1Data,
   output logic [femtoPkg::XLEN-1:0]       rs2Data
);
   import femtoPkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];
   logic [XLEN-1:0] wbData;

   // Write-back mux
   always_comb begin
      case (wbSel)
         wbUpperImm:     wbData = immU;          // LUI
         wbBranchTarget: wbData = branchTarget;  // AUIPC
         wbPcPlus4:      wbData = pcPlus4;       // JAL, JALR link
         wbLoadData:     wbData = memRdata;
         default:        wbData = aluResult;
      endcase
   end

   // Reads land one cycle later, x0 forced to zero
   always_ff @(posedge clk) begin
      rs1Data <= (rs1 == '0) ? '0 : regs[rs1];
      rs2Data <= (rs2 == '0) ? '0 : regs[rs2];
      if (regWrite && (rd != '0)) begin
         regs[rd] <= wbData;
      end
   end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps
// ALU with shared adder and one 33-bit subtract for SUB and compares
// Shifts run serially, one bit per cycle, while busy is high
module alu (
   input  logic                      clk,
   input  logic                      aluStart,
   input  logic [femtoPkg::XLEN-1:0] rs1Data,
   input  logic [femtoPkg::XLEN-1:0] rs2Data,
   input  logic [femtoPkg::XLEN-1:0] immI,
   input  logic [femtoPkg::XLEN-1:0] immS,
   input  femtoPkg::opcodeT          opcode,
   input  logic [2:0]                funct3,
   input  logic                      altFn,
   output logic [femtoPkg::XLEN-1:0] aluSum,
   output logic [femtoPkg::XLEN-1:0] aluResult,
   output logic                      eq,
   output logic                      lt,
   output logic                      ltu,
   output logic                      busy
);
   import femtoPkg::*;

   logic [XLEN-1:0]    in2;
   logic [XLEN:0]      diff;          // Bit XLEN is the borrow
   logic [XLEN-1:0]    aluReg;        // Result, also the shift register
   logic [SHAMT_W-1:0] shamt = '0;    // Remaining shift steps
   aluFnT              fn;

   assign fn = aluFnT'(funct3);

   // Second operand
   assign in2 = (opcode == opAluReg || opcode == opBranch) ? rs2Data :
                (opcode == opStore) ? immS : immI;

   assign aluSum = rs1Data + in2;  // Also load/store/JALR address
   assign diff   = {1'b0, rs1Data} - {1'b0, in2};

   // ********************
   // Compare flags
   assign eq  = (diff[XLEN-1:0] == '0);
   assign ltu = diff[XLEN];
   assign lt  = (rs1Data[XLEN-1] ^ in2[XLEN-1]) ? rs1Data[XLEN-1] : diff[XLEN];

   assign busy      = (shamt != '0);
   assign aluResult = aluReg;

   // ********************
   // Operation and serial shift
   always_ff @(posedge clk) begin
      if (aluStart) begin
         case (fn)
            fnAddSub: aluReg <= (altFn && opcode == opAluReg) ? diff[XLEN-1:0] : aluSum;
            fnSlt:    aluReg <= {{(XLEN-1){1'b0}}, lt};
            fnSltu:   aluReg <= {{(XLEN-1){1'b0}}, ltu};
            fnXor:    aluReg <= rs1Data ^ in2;
            fnOr:     aluReg <= rs1Data | in2;
            fnAnd:    aluReg <= rs1Data & in2;
            fnSll, fnSrlSra: begin
               aluReg <= rs1Data;               // Operand, shifted below
               shamt  <= in2[SHAMT_W-1:0];
            end
         endcase
      end else if (busy) begin
         shamt <= shamt - 1'b1;
         if (fn == fnSll) begin
            aluReg <= aluReg << 1;
         end else begin
            aluReg <= {altFn & aluReg[XLEN-1], aluReg[XLEN-1:1]};  // SRA keeps sign
         end
      end
   end

   // Sequencer must hold off a new op until the shift drains
   assert property (@(posedge clk) aluStart |-> !busy);

endmodule

//--- rtl/pcUnit.sv
`timescale 1ns/1ps
// Program counter, branch decision and memory address register
// PC and address update on the execute cycle, address reloads on addrToPc
module pcUnit #(
   parameter logic [femtoPkg::XLEN-1:0] RESET_ADDR = '0
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      pcUpdate,
   input  logic                      addrToPc,
   input  femtoPkg::opcodeT          opcode,
   input  logic [2:0]                funct3,
   input  logic                      eq,
   input  logic                      lt,
   input  logic                      ltu,
   input  logic [femtoPkg::XLEN-1:0] aluSum,
   input  logic [femtoPkg::XLEN-1:0] immB,
   input  logic [femtoPkg::XLEN-1:0] immU,
   input  logic [femtoPkg::XLEN-1:0] immJ,
   output logic [femtoPkg::XLEN-1:0] pc,
   output logic [femtoPkg::XLEN-1:0] pcPlus4,
   output logic [femtoPkg::XLEN-1:0] branchTarget,
   output logic [femtoPkg::XLEN-1:0] memAddr
);
   import femtoPkg::*;

   branchCondT      cond;
   logic            predicate;
   logic            takeBranch;
   logic            useSum;       // Address comes from the ALU adder
   logic [XLEN-1:0] offset;
   logic [XLEN-1:0] nextPc;

   assign cond = branchCondT'(funct3);

   always_comb begin
      case (cond)
         brBeq:   predicate = eq;
         brBne:   predicate = !eq;
         brBlt:   predicate = lt;
         brBge:   predicate = !lt;
         brBltu:  predicate = ltu;
         brBgeu:  predicate = !ltu;
         default: predicate = 1'b0;   // Reserved codes never taken
      endcase
   end

   // One adder for branch, JAL and AUIPC
   assign offset       = (opcode == opJal) ? immJ : (opcode == opAuipc) ? immU : immB;
   assign branchTarget = pc + offset;
   assign pcPlus4      = pc + XLEN'(4);

   assign takeBranch = (opcode == opJal) || (opcode == opBranch && predicate);
   assign nextPc     = (opcode == opJalr) ? aluSum : (takeBranch ? branchTarget : pcPlus4);
   assign useSum     = opcode inside {opAluImm, opAluReg, opLoad, opStore};

   always_ff @(posedge clk) begin
      if (!reset) begin
         pc      <= RESET_ADDR;
         memAddr <= RESET_ADDR;
      end else if (pcUpdate) begin
         pc      <= nextPc;
         memAddr <= useSum ? aluSum : nextPc;  // Data address or next fetch
      end else if (addrToPc) begin
         memAddr <= pc;                        // Back to fetch address
      end
   end

endmodule

//--- rtl/coreControl.sv
`timescale 1ns/1ps
// Eight-state one-hot sequencer of the core
// Generates memory strobes, write mask and datapath enables from the state
module coreControl (
   input  logic                         clk,
   input  logic                         reset,
   input  femtoPkg::opcodeT             opcode,
   input  logic                         aluBusy,
   input  logic                         memRbusy,
   input  logic                         memWbusy,
   output femtoPkg::coreStateT          state,
   output logic                         instrLoad,
   output logic                         regWrite,
   output logic                         aluStart,
   output logic                         pcUpdate,
   output logic                         addrToPc,
   output logic                         memRstrb,
   output logic [femtoPkg::WMASK_W-1:0] memWmask
);
   import femtoPkg::*;

   logic isAlu;
   logic noWrite;    // Branch or store, nothing to write back
   logic waitDone;   // All back-pressure released

   assign isAlu    = (opcode == opAluImm) || (opcode == opAluReg);
   assign noWrite  = (opcode == opBranch) || (opcode == opStore);
   assign waitDone = !aluBusy && !memRbusy && !memWbusy;

   // ********************
   // Enables and strobes
   assign instrLoad = (state == waitInstr) && !memRbusy;
   assign pcUpdate  = (state == execute);
   assign aluStart  = pcUpdate && isAlu;
   assign regWrite  = (pcUpdate && !noWrite) || (state == waitAluOrData);
   assign addrToPc  = (state == waitAluOrData || state == waitIoStore) && waitDone;
   assign memRstrb  = (state == fetchInstr) || (state == load);
   assign memWmask  = {WMASK_W{state == store}};  // Word stores only

   // ********************
   // State register
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= waitIoStore;  // Leaves once memWbusy is low
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) begin
                  state <= fetchRegs;
               end
            end
            fetchRegs: state <= execute;
            execute: begin
               if (opcode == opStore) begin
                  state <= store;
               end else if (isAlu) begin
                  state <= waitAluOrData;  // Result or shift drain
               end else if (opcode == opLoad) begin
                  state <= load;
               end else begin
                  state <= fetchInstr;     // Jumps, branches, LUI, AUIPC
               end
            end
            load:  state <= waitAluOrData;
            store: state <= waitIoStore;
            waitAluOrData, waitIoStore: begin
               if (waitDone) begin
                  state <= fetchInstr;
               end
            end
            default: state <= waitIoStore;
         endcase
      end
   end

   // Exactly one state bit at all times
   assert property (@(posedge clk) disable iff (!reset) $onehot(state));

   // Read strobe and write mask never overlap
   assert property (@(posedge clk) disable iff (!reset) !(memRstrb && (|memWmask)));

endmodule

//--- rtl/femtoCore.sv
`timescale 1ns/1ps
// Top level of the multi-cycle RV32I core
// Connects sequencer and datapath to the strobe/busy memory port
module femtoCore #(
   parameter logic [femtoPkg::XLEN-1:0] RESET_ADDR = '0
) (
   input  logic                         clk,
   input  logic                         reset,
   output logic [femtoPkg::XLEN-1:0]    memAddr,
   output logic [femtoPkg::XLEN-1:0]    memWdata,
   output logic [femtoPkg::WMASK_W-1:0] memWmask,
   input  logic [femtoPkg::XLEN-1:0]    memRdata,
   output logic                         memRstrb,
   input  logic                         memRbusy,
   input  logic                         memWbusy
);
   import femtoPkg::*;

   // Control
   logic      instrLoad;
   logic      regWrite;
   logic      aluStart;
   logic      pcUpdate;
   logic      addrToPc;

   // Decoded instruction
   opcodeT                opcode;
   wbSelT                 wbSel;
   logic [REG_ADDR_W-1:0] rd;
   logic [REG_ADDR_W-1:0] rs1;
   logic [REG_ADDR_W-1:0] rs2;
   logic [2:0]            funct3;
   logic                  altFn;
   logic [XLEN-1:0]       immI;
   logic [XLEN-1:0]       immS;
   logic [XLEN-1:0]       immB;
   logic [XLEN-1:0]       immU;
   logic [XLEN-1:0]       immJ;

   // Datapath
   logic [XLEN-1:0] rs1Data;
   logic [XLEN-1:0] rs2Data;
   logic [XLEN-1:0] aluSum;
   logic [XLEN-1:0] aluResult;
   logic            eq;
   logic            lt;
   logic            ltu;
   logic            aluBusy;
   logic [XLEN-1:0] pcPlus4;
   logic [XLEN-1:0] branchTarget;

   assign memWdata = rs2Data;  // Store data straight from the register read

   coreControl uControl (
      .clk(clk), .reset(reset), .opcode(opcode), .aluBusy(aluBusy),
      .memRbusy(memRbusy), .memWbusy(memWbusy), .state(),
      .instrLoad(instrLoad), .regWrite(regWrite), .aluStart(aluStart),
      .pcUpdate(pcUpdate), .addrToPc(addrToPc), .memRstrb(memRstrb), .memWmask(memWmask)
   );

   instrDecoder uDecoder (
      .clk(clk), .instrLoad(instrLoad), .memRdata(memRdata),
      .rd(rd), .rs1(rs1), .rs2(rs2), .funct3(funct3), .altFn(altFn),
      .opcode(opcode), .wbSel(wbSel),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   registerBank uRegs (
      .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .regWrite(regWrite), .wbSel(wbSel),
      .aluResult(aluResult), .immU(immU), .branchTarget(branchTarget),
      .pcPlus4(pcPlus4), .memRdata(memRdata), .rs1Data(rs1Data), .rs2Data(rs2Data)
   );

   alu uAlu (
      .clk(clk), .aluStart(aluStart), .rs1Data(rs1Data), .rs2Data(rs2Data),
      .immI(immI), .immS(immS), .opcode(opcode), .funct3(funct3), .altFn(altFn),
      .aluSum(aluSum), .aluResult(aluResult), .eq(eq), .lt(lt), .ltu(ltu), .busy(aluBusy)
   );

   pcUnit #(.RESET_ADDR(RESET_ADDR)) uPc (
      .clk(clk), .reset(reset), .pcUpdate(pcUpdate), .addrToPc(addrToPc),
      .opcode(opcode), .funct3(funct3), .eq(eq), .lt(lt), .ltu(ltu), .aluSum(aluSum),
      .immB(immB), .immU(immU), .immJ(immJ), .pc(), .pcPlus4(pcPlus4),
      .branchTarget(branchTarget), .memAddr(memAddr)
   );

endmodule

//--- verification/coreChecker.sv
`timescale 1ns/1ps
// Instruction-set model of the RV32I core for the testbench
// Watches the memory port at the falling edge and steps one instruction per fetch
// Program and data words arrive through loadWord before the run starts
module coreChecker #(
   parameter logic [31:0] RESET_ADDR = '0,
   parameter int          MEM_WORDS  = 4096
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [31:0] memAddr,
   input  logic [31:0] memWdata,
   input  logic [3:0]  memWmask,
   input  logic        memRstrb,
   output logic        done,         // Final self loop reached
   output int          errorCount,
   output int          checkCount
);

   localparam int EXP_FETCH = 0;
   localparam int EXP_LOAD  = 1;
   localparam int EXP_STORE = 2;

   logic [31:0] mem [MEM_WORDS];   // Unified program and data memory
   logic [31:0] regs [32];
   logic [31:0] pc;
   int          pending;           // Next memory access the model waits for
   logic [31:0] expAddr;
   logic [31:0] expData;

   task loadWord(input int idx, input logic [31:0] w);
      mem[idx] = w;
   endtask

   task compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      checkCount++;
      if (act !== exp) begin
         errorCount++;
         $display("error: time %0t ns, %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task failNote(input string what);
      errorCount++;
      $display("error: time %0t ns, %s", $time, what);
   endtask

   // RV32I integer operations by funct3
   function automatic logic [31:0] aluOp(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
      logic [31:0] res;
      logic [4:0]  sh;
      sh = b[4:0];
      case (f3)
         3'd0: res = alt ? a - b : a + b;
         3'd1: res = a << sh;
         3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: res = (a < b) ? 32'd1 : 32'd0;
         3'd4: res = a ^ b;
         3'd5: begin
            if (alt) begin
               res = $signed(a) >>> sh;   // Sign fill
            end else begin
               res = a >> sh;
            end
         end
         3'd6: res = a | b;
         default: res = a & b;
      endcase
      return res;
   endfunction

   // ********************
   // One instruction of the model
   task step();
      logic [31:0] instr;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] val;
      logic [31:0] nextPc;
      logic        wr;
      logic        taken;
      instr  = mem[pc[13:2]];
      a      = regs[instr[19:15]];
      b      = regs[instr[24:20]];
      nextPc = pc + 32'd4;
      wr     = 1'b1;
      val    = pc + 32'd4;                                   // Link value
      case (instr[6:0])
         7'b0110111: val = {instr[31:12], 12'b0};            // LUI
         7'b0010111: val = pc + {instr[31:12], 12'b0};       // AUIPC
         7'b1101111: nextPc = pc + {{12{instr[31]}}, instr[19:12], instr[20],
                                    instr[30:21], 1'b0};     // JAL
         7'b1100111: nextPc = (a + {{20{instr[31]}}, instr[31:20]}) & ~32'd1;
         7'b1100011: begin
            wr = 1'b0;
            case (instr[14:12])
               3'd0:    taken = (a == b);
               3'd1:    taken = (a != b);
               3'd4:    taken = ($signed(a) < $signed(b));
               3'd5:    taken = ($signed(a) >= $signed(b));
               3'd6:    taken = (a < b);
               default: taken = (a >= b);
            endcase
            if (taken) begin
               nextPc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
         end
         7'b0000011: begin                                   // LW
            expAddr = a + {{20{instr[31]}}, instr[31:20]};
            val     = mem[expAddr[13:2]];
            pending = EXP_LOAD;
         end
         7'b0100011: begin                                   // SW
            wr      = 1'b0;
            expAddr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            expData = b;
            mem[expAddr[13:2]] = b;
            pending = EXP_STORE;
         end
         7'b0010011: val = aluOp(instr[14:12], (instr[14:12] == 3'd5) && instr[30], a,
                                 {{20{instr[31]}}, instr[31:20]});
         7'b0110011: val = aluOp(instr[14:12], instr[30], a, b);
         default: begin
            wr = 1'b0;
            failNote("model fetched an unsupported opcode");
         end
      endcase
      if (wr && instr[11:7] != 5'd0) begin
         regs[instr[11:7]] = val;                            // x0 stays zero
      end
      if (nextPc == pc) begin
         done = 1'b1;
      end
      pc = nextPc;
   endtask

   // ********************
   // Port watcher, outputs stable mid cycle
   always @(negedge clk) begin
      if (!reset) begin
         pc         = RESET_ADDR;
         pending    = EXP_FETCH;
         done       = 1'b0;
         errorCount = 0;
         checkCount = 0;
         for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
         end
      end else begin
         if (memRstrb && memWmask != 4'd0) begin
            failNote("read strobe and write mask active in the same cycle");
         end
         if (memRstrb) begin
            if (pending == EXP_FETCH) begin
               compare("memAddr", pc, memAddr);   // Fetch address
               step();
            end else if (pending == EXP_LOAD) begin
               compare("memAddr", expAddr, memAddr);
               pending = EXP_FETCH;
            end else begin
               failNote("read strobe seen while a store was due");
            end
         end
         if (memWmask != 4'd0) begin
            if (pending == EXP_STORE) begin
               compare("memAddr", expAddr, memAddr);
               compare("memWmask", 32'hf, {28'b0, memWmask});
               compare("memWdata", expData, memWdata);
               pending = EXP_FETCH;
            end else begin
               failNote("write mask active with no store pending");
            end
         end
      end
   end

endmodule

//--- verification/tbFemtoCore.sv
`timescale 1ns/1ps
// Testbench of the RV32I core
// Generates a random program in blocks, serves the memory port with random
// busy stalls and leaves all comparing to coreChecker
module tbFemtoCore;

   localparam logic [31:0] RESET_ADDR = 32'h0000_0100;
   localparam int          MEM_WORDS  = 4096;
   localparam int          NUM_BLOCKS = 20;
   localparam int          BLOCK_LEN  = 10;
   localparam logic [6:0]  OP_LUI     = 7'b0110111;
   localparam logic [6:0]  OP_AUIPC   = 7'b0010111;
   localparam logic [6:0]  OP_IMM     = 7'b0010011;
   localparam logic [6:0]  OP_REG     = 7'b0110011;
   localparam logic [6:0]  OP_LOAD    = 7'b0000011;
   localparam logic [6:0]  OP_JALR    = 7'b1100111;

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata;
   logic        memRstrb;
   logic        memRbusy;
   logic        memWbusy;
   logic        done;
   int          errorCount;
   int          checkCount;

   logic [31:0] mem [MEM_WORDS];
   integer      seed;
   int          pcW;             // Next program word index
   int          progWords = 0;
   int          cycles = 0;
   int          limit;
   int          rdLeft = 0;      // Busy cycles left on the read side
   int          wrLeft = 0;
   logic [31:0] rdAddr;
   logic        rdReq;
   logic        wrReq;
   logic [31:0] reqAddr;

   femtoCore #(.RESET_ADDR(RESET_ADDR)) uut (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRdata(memRdata), .memRstrb(memRstrb),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   coreChecker #(.RESET_ADDR(RESET_ADDR), .MEM_WORDS(MEM_WORDS)) chk (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRstrb(memRstrb), .done(done),
      .errorCount(errorCount), .checkCount(checkCount)
   );

   always #5 clk = ~clk;
   always @(posedge clk) cycles <= cycles + 1;

   function automatic int randBelow(input int n);
      return {$random(seed)} % n;
   endfunction

   // ********************
   // RV32I instruction formats
   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // SW only
   endfunction

   function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
         input logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   task emit(input logic [31:0] w);
      mem[pcW] = w;
      chk.loadWord(pcW, w);   // Model sees the same word
      pcW++;
      progWords++;
   endtask

   // One block of random instructions, control flow stays forward and inside
   task genBlock(input int n);
      int          base;
      int          i;
      int          t;
      int          kind;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  sh;
      logic [2:0]  f3;
      logic        alt;
      logic [11:0] imm;
      logic [31:0] target;
      logic [19:0] hi;
      base = pcW;
      while (pcW < base + n) begin
         i    = pcW - base;
         kind = randBelow(10);
         rd   = randBelow(30);                 // x30 and x31 reserved
         rs1  = randBelow(32);
         rs2  = (randBelow(4) == 0) ? rs1 : randBelow(32);   // Equal operands now and then
         f3   = randBelow(8);
         alt  = randBelow(2);
         sh   = randBelow(32);
         t    = i + 1 + randBelow(n - i);      // Forward target, block end allowed
         if (kind == 9 && n - i < 2) begin
            kind = 8;                          // No room for LUI plus JALR
         end
         case (kind)
            0, 1: emit(rType({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0}, rs2, rs1, f3, rd));
            2, 3: begin
               if (f3 == 3'd1) begin
                  imm = {7'b0, sh};
               end else if (f3 == 3'd5) begin
                  imm = {1'b0, alt, 5'b0, sh};    // SRLI or SRAI
               end else begin
                  imm = $random(seed);
               end
               emit(iType(imm, rs1, f3, rd, OP_IMM));
            end
            4: emit(uType($random(seed), rd, alt ? OP_LUI : OP_AUIPC));
            5: emit(iType(4 * randBelow(16), 5'd31, 3'b010, rd, OP_LOAD));  // Small window
            6: emit(sType(4 * randBelow(16), rs2, 5'd31));   // Loads hit earlier stores
            7: begin
               t = (randBelow(6));                 // Six branch codes
               emit(bType(4 * (i + 1 + randBelow(n - i) - i), rs2, rs1,
                          (t < 2) ? t : t + 2));
            end
            8: emit(jType(4 * (t - i), rd));
            default: begin
               t      = i + 2 + randBelow(n - i - 1);   // Past the JALR itself
               target = (base + t) * 4;
               hi     = (target + 32'h800) >> 12;
               emit(uType(hi, 5'd30, OP_LUI));
               emit(iType(target - {hi, 12'b0}, 5'd30, 3'b000, rd, OP_JALR));
            end
         endcase
      end
   endtask

   task genProgram();
      for (int i = 0; i < MEM_WORDS; i++) begin
         emitFill(i);
      end
      pcW = RESET_ADDR >> 2;
      for (int r = 1; r < 30; r++) begin      // Full-range start values
         emit(uType($random(seed), r, OP_LUI));
         emit(iType($random(seed), r, 3'b000, r, OP_IMM));
      end
      emit(uType(20'h0, 5'd30, OP_LUI));
      emit(uType(20'h2, 5'd31, OP_LUI));      // Data base 0x2000
      for (int b = 0; b < NUM_BLOCKS; b++) begin
         genBlock(BLOCK_LEN);
      end
      for (int k = 0; k < 32; k++) begin      // Dump all registers, x0 too
         emit(sType(1920 + 4 * k, k, 5'd31));
      end
      emit(jType(21'd0, 5'd0));               // Jump to itself
   endtask

   // Fill pattern over the byte address
   task emitFill(input int idx);
      logic [31:0] addr;
      logic [31:0] w;
      addr = idx * 4;
      w    = (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
      mem[idx] = w;
      chk.loadWord(idx, w);
   endtask

   // ********************
   // Memory model, sample mid cycle, drive 1 ns after the rising edge
   always begin
      @(negedge clk);
      rdReq   = memRstrb;
      wrReq   = (memWmask != 4'd0);
      reqAddr = memAddr;
      if (wrReq) begin
         mem[reqAddr[13:2]] = memWdata;
      end
      @(posedge clk);
      #1;
      if (rdReq) begin
         rdLeft   = randBelow(4);
         rdAddr   = reqAddr;
         memRbusy = (rdLeft != 0);
         if (rdLeft == 0) begin
            memRdata = mem[reqAddr[13:2]];
         end
      end else if (rdLeft > 0) begin
         rdLeft--;
         if (rdLeft == 0) begin
            memRbusy = 1'b0;
            memRdata = mem[rdAddr[13:2]];   // Data with busy release
         end
      end
      if (wrReq) begin
         wrLeft   = randBelow(4);
         memWbusy = (wrLeft != 0);
      end else if (wrLeft > 0) begin
         wrLeft--;
         memWbusy = (wrLeft != 0);
      end
   end

   initial begin
      seed     = 32'h2e7f_8527;
      clk      = 1'b0;
      reset    = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      genProgram();
      limit = progWords * 45;                 // Worst case per instruction
      repeat (2) @(posedge clk);
      #1 reset = 1'b1;
      while (!done && cycles < limit) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
      if (!done) begin
         $display("timeout: the program did not reach its final loop in %0d cycles", limit);
      end
      $display("checks %0d, errors %0d, cycles %0d", checkCount, errorCount, cycles);
      if (done && errorCount == 0 && checkCount > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- sources.f
rtl/femtoPkg.sv
rtl/instrDecoder.sv
rtl/registerBank.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/coreControl.sv
rtl/femtoCore.sv
verification/coreChecker.sv
verification/tbFemtoCore.sv
